/* rtl/ncpu_cfg_pkg.sv */
package ncpu_cfg_pkg;

   // Data path
   localparam int unsigned DW = 32;                  // Architectural data word

   // Program counter, word aligned so the two low bits are dropped
   localparam int unsigned PC_W = 30;

   // Rename
   localparam int unsigned PRF_AW = 6;               // Physical register index

   // Commit geometry
   // log2 of the number of ROB slots examined per cycle,
   // giving four slots with the default setting
   localparam int unsigned P_COMMIT_WIDTH_DFLT = 2;

endpackage

/* rtl/cmt_ops_pkg.sv */
package cmt_ops_pkg;

   // Opcode buses, one field per commit slot
   localparam int unsigned LSU_IOPW = 4;             // Non-zero means load/store
   localparam int unsigned EPU_IOPW = 6;             // Non-zero means EPU operation

   // Branch update word as recorded by the BPU at fetch time
   localparam int unsigned BPU_UPD_W = 32;           // Per slot

   // Field layout of the update word
   // bit 0 holds the predicted direction, the predicted
   // target PC starts at bit 1 and spans a full word-aligned PC
   localparam int unsigned BPU_UPD_TAKEN = 0;        // Predicted taken
   localparam int unsigned BPU_UPD_TGT_LSB = 1;      // Predicted target LSB

endpackage

/* rtl/cmt_ctl_if.sv */
interface cmt_ctl_if
(
   input logic clk,
   input logic rst_n
);

   logic head_valid;                                 // ROB head holds an op
   logic head_lsu_req;                               // Head needs the LSU
   logic head_epu_req;                               // Head needs the EPU
   logic head_fire;                                  // Head retires this cycle
   logic commit_en;                                  // No unit op outstanding
   logic se_fls;                                     // Self-flush, one cycle
   logic flush;                                      // Self or exception flush

   modport sel
   (
      input  clk, rst_n,
      input  commit_en, se_fls, flush,
      output head_lsu_req, head_epu_req, head_fire
   );

   modport seq
   (
      input  head_valid, head_lsu_req, head_epu_req, flush,
      output commit_en
   );

   modport redir
   (
      input  head_fire,
      output se_fls, flush
   );

endinterface

/* rtl/cmt_sel.sv */
module cmt_sel
   import ncpu_cfg_pkg::*;
   import cmt_ops_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = P_COMMIT_WIDTH_DFLT
)
(
   cmt_ctl_if.sel                           ctl,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_valid,
   input  logic [LSU_IOPW*(1<<P_COMMIT_WIDTH)-1:0] cmt_lsu_opc_bus,
   input  logic [EPU_IOPW*(1<<P_COMMIT_WIDTH)-1:0] cmt_epu_opc_bus,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_exc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_fls,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_is_bcc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_is_breg,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_is_brel,
   output logic [(1<<P_COMMIT_WIDTH)-1:0]   cmt_fire,
   output logic [P_COMMIT_WIDTH:0]          cmt_pop_size
);

   localparam int CW = 1 << P_COMMIT_WIDTH;

   logic [CW-1:0] lsu_req;
   logic [CW-1:0] epu_req;
   logic [CW-1:0] is_br;
   logic [CW-1:0] single_fu;
   logic [CW-1:0] retire_mask;

   // Unit needs are masked while the self-flush drains the ROB
   for (genvar i = 0; i < CW; i++)
   begin : g_slot
      assign lsu_req[i] = ~ctl.se_fls & (|cmt_lsu_opc_bus[i*LSU_IOPW +: LSU_IOPW]);
      assign epu_req[i] = ~ctl.se_fls &
                          ((|cmt_epu_opc_bus[i*EPU_IOPW +: EPU_IOPW]) | cmt_exc[i]);
      assign is_br[i]   = cmt_is_bcc[i] | cmt_is_breg[i] | cmt_is_brel[i];
   end

   // These slots must retire alone at the head
   assign single_fu = lsu_req | epu_req | cmt_fls | is_br;

   always_comb
   begin
      retire_mask[0] = ctl.commit_en & ~ctl.flush;
      // Slot 1 also checks itself, so a single-unit op waits to become head
      retire_mask[1] = retire_mask[0] & ~single_fu[0] & ~single_fu[1];
      for (int k = 2; k < CW; k++)
         retire_mask[k] = retire_mask[k-1] & ~single_fu[k];
   end

   assign cmt_fire = cmt_valid & retire_mask;

   always_comb
   begin
      cmt_pop_size = '0;
      for (int k = 0; k < CW; k++)
         cmt_pop_size = cmt_pop_size + {{P_COMMIT_WIDTH{1'b0}}, cmt_fire[k]};
   end

   assign ctl.head_lsu_req = lsu_req[0];
   assign ctl.head_epu_req = epu_req[0];
   assign ctl.head_fire    = cmt_fire[0];

   // ROB pops exactly the slots that were reported as fired
   a_pop_size: assert property (@(posedge ctl.clk) disable iff (!ctl.rst_n)
      cmt_pop_size == $countones(cmt_fire))
      else $error("pop size %0d disagrees with fire vector %b", cmt_pop_size, cmt_fire);

endmodule

/* rtl/cmt_fu_seq.sv */
module cmt_fu_seq
   import ncpu_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   cmt_ctl_if.seq            ctl,
   input  logic              lsu_wb_valid,
   input  logic [DW-1:0]     lsu_wb_dout,
   input  logic              epu_wb_valid,
   input  logic [DW-1:0]     epu_wb_dout,
   input  logic              epu_wb_dout_sel,
   input  logic              cmt_prd_we0,
   input  logic [PRF_AW-1:0] cmt_prd0,
   output logic              lsu_req_valid,
   output logic              epu_req_valid,
   output logic              prf_we,
   output logic [PRF_AW-1:0] prf_waddr,
   output logic [DW-1:0]     prf_wdata
);

   localparam logic [1:0] S_IDLE    = 2'b01;
   localparam logic [1:0] S_PENDING = 2'b10;

   logic [1:0] state_q;
   logic [1:0] state_d;
   logic       pipe_req;
   logic       pipe_finish;

   assign pipe_req    = ctl.head_valid & (ctl.head_lsu_req | ctl.head_epu_req);
   assign pipe_finish = lsu_wb_valid | epu_wb_valid;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_IDLE:
            if (pipe_req)
               state_d = S_PENDING;
         S_PENDING:
            if (pipe_finish)
               state_d = S_IDLE;                     // Head retires on the pulse
         default:
            state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= S_IDLE;
      else
         state_q <= state_d;
   end

   // Request is a level held only in the issuing cycle
   assign lsu_req_valid = (state_q == S_IDLE) & ctl.head_valid & ctl.head_lsu_req;
   assign epu_req_valid = (state_q == S_IDLE) & ctl.head_valid & ctl.head_epu_req;

   // Stall whole commit while a unit op is outstanding
   assign ctl.commit_en = ~pipe_req | pipe_finish;

   assign prf_we    = pipe_finish & ~ctl.flush & cmt_prd_we0;
   assign prf_waddr = cmt_prd0;
   assign prf_wdata = epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout;

   // External units only answer a request this stage issued
   a_no_idle_wb: assert property (@(posedge clk) disable iff (!rst_n)
      pipe_finish |-> (state_q == S_PENDING))
      else $error("unit completion while no request is outstanding");

   a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
      !(lsu_req_valid && epu_req_valid))
      else $error("LSU and EPU requested together");

endmodule

/* rtl/cmt_redirect.sv */
module cmt_redirect
   import ncpu_cfg_pkg::*;
   import cmt_ops_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   cmt_ctl_if.redir             ctl,
   input  logic                 cmt_fls0,
   input  logic [PC_W-1:0]      cmt_pc0,
   input  logic [DW-1:0]        cmt_opera0,
   input  logic                 refetch,
   input  logic                 exc_flush,
   input  logic [PC_W-1:0]      exc_flush_tgt,
   input  logic                 cmt_is_bcc0,
   input  logic                 cmt_is_breg0,
   input  logic                 cmt_is_brel0,
   input  logic [BPU_UPD_W-1:0] cmt_bpu_upd0,
   output logic [PC_W-1:0]      flush_tgt,
   output logic                 bpu_wb,
   output logic                 bpu_wb_is_bcc,
   output logic                 bpu_wb_is_breg,
   output logic                 bpu_wb_is_brel,
   output logic                 bpu_wb_taken,
   output logic [PC_W-1:0]      bpu_wb_pc,
   output logic [PC_W-1:0]      bpu_wb_npc_act,
   output logic [BPU_UPD_W-1:0] bpu_wb_upd
);

   logic [PC_W-1:0] npc0;
   logic [PC_W-1:0] act_tgt;
   logic            se_fls_d;
   logic [PC_W-1:0] se_tgt_d;
   logic            se_fls_q;
   logic [PC_W-1:0] se_tgt_q;

   assign npc0    = cmt_pc0 + 1'b1;                  // Sequential successor
   assign act_tgt = cmt_opera0[PC_W-1:0];            // Resolved branch target

   // Set only by a firing head, nothing fires while it is high
   assign se_fls_d = ctl.head_fire & (cmt_fls0 | refetch);
   assign se_tgt_d = cmt_fls0 ? act_tgt : npc0;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         se_fls_q <= 1'b0;
      else
         se_fls_q <= se_fls_d;
   end

   always_ff @(posedge clk)
   begin
      if (ctl.head_fire)
         se_tgt_q <= se_tgt_d;
   end

   assign ctl.se_fls = se_fls_q;
   assign ctl.flush  = se_fls_q | exc_flush;
   assign flush_tgt  = se_fls_q ? se_tgt_q : exc_flush_tgt;   // Self-flush wins

   assign bpu_wb         = ctl.head_fire & (cmt_is_bcc0 | cmt_is_breg0 | cmt_is_brel0);
   assign bpu_wb_is_bcc  = cmt_is_bcc0;
   assign bpu_wb_is_breg = cmt_is_breg0;
   assign bpu_wb_is_brel = cmt_is_brel0;
   // Mispredict flips the predicted direction
   assign bpu_wb_taken   = cmt_bpu_upd0[BPU_UPD_TAKEN] ^ cmt_fls0;
   assign bpu_wb_pc      = cmt_pc0;
   assign bpu_wb_npc_act = cmt_fls0 ? act_tgt : cmt_bpu_upd0[BPU_UPD_TGT_LSB +: PC_W];
   assign bpu_wb_upd     = cmt_bpu_upd0;

   // Self-flush is a single-cycle pulse
   a_se_fls_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      se_fls_q |=> !se_fls_q)
      else $error("self-flush held for two cycles");

endmodule

/* rtl/cmt_top.sv */
module cmt_top
   import ncpu_cfg_pkg::*;
   import cmt_ops_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = P_COMMIT_WIDTH_DFLT
)
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   // From ROB
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_valid,
   input  logic [LSU_IOPW*(1<<P_COMMIT_WIDTH)-1:0]   cmt_lsu_opc_bus,
   input  logic [EPU_IOPW*(1<<P_COMMIT_WIDTH)-1:0]   cmt_epu_opc_bus,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_exc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_fls,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_is_bcc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_is_breg,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_is_brel,
   input  logic [PC_W*(1<<P_COMMIT_WIDTH)-1:0]       cmt_pc,
   input  logic [DW*(1<<P_COMMIT_WIDTH)-1:0]         cmt_opera,
   input  logic [BPU_UPD_W*(1<<P_COMMIT_WIDTH)-1:0]  cmt_bpu_upd,
   input  logic [PRF_AW*(1<<P_COMMIT_WIDTH)-1:0]     cmt_prd,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_prd_we,
   // From LSU and EPU
   input  logic                                      lsu_wb_valid,
   input  logic [DW-1:0]                             lsu_wb_dout,
   input  logic                                      epu_wb_valid,
   input  logic [DW-1:0]                             epu_wb_dout,
   input  logic                                      epu_wb_dout_sel,
   input  logic                                      exc_flush,
   input  logic [PC_W-1:0]                           exc_flush_tgt,
   input  logic                                      refetch,
   // To ROB
   output logic [(1<<P_COMMIT_WIDTH)-1:0]            cmt_fire,
   output logic [P_COMMIT_WIDTH:0]                   cmt_pop_size,
   // To LSU and EPU
   output logic                                      lsu_req_valid,
   output logic                                      epu_req_valid,
   // To PRF
   output logic                                      prf_we,
   output logic [PRF_AW-1:0]                         prf_waddr,
   output logic [DW-1:0]                             prf_wdata,
   // To frontend
   output logic                                      flush,
   output logic [PC_W-1:0]                           flush_tgt,
   output logic                                      bpu_wb,
   output logic                                      bpu_wb_is_bcc,
   output logic                                      bpu_wb_is_breg,
   output logic                                      bpu_wb_is_brel,
   output logic                                      bpu_wb_taken,
   output logic [PC_W-1:0]                           bpu_wb_pc,
   output logic [PC_W-1:0]                           bpu_wb_npc_act,
   output logic [BPU_UPD_W-1:0]                      bpu_wb_upd
);

   cmt_ctl_if ctl_i (.clk(clk), .rst_n(rst_n));

   assign ctl_i.head_valid = cmt_valid[0];
   assign flush            = ctl_i.flush;

   cmt_sel #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH)) u_sel
   (
      .ctl             (ctl_i.sel),
      .cmt_valid       (cmt_valid),
      .cmt_lsu_opc_bus (cmt_lsu_opc_bus),
      .cmt_epu_opc_bus (cmt_epu_opc_bus),
      .cmt_exc         (cmt_exc),
      .cmt_fls         (cmt_fls),
      .cmt_is_bcc      (cmt_is_bcc),
      .cmt_is_breg     (cmt_is_breg),
      .cmt_is_brel     (cmt_is_brel),
      .cmt_fire        (cmt_fire),
      .cmt_pop_size    (cmt_pop_size)
   );

   cmt_fu_seq u_fu_seq
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .ctl             (ctl_i.seq),
      .lsu_wb_valid    (lsu_wb_valid),
      .lsu_wb_dout     (lsu_wb_dout),
      .epu_wb_valid    (epu_wb_valid),
      .epu_wb_dout     (epu_wb_dout),
      .epu_wb_dout_sel (epu_wb_dout_sel),
      .cmt_prd_we0     (cmt_prd_we[0]),
      .cmt_prd0        (cmt_prd[PRF_AW-1:0]),        // Only the head writes back
      .lsu_req_valid   (lsu_req_valid),
      .epu_req_valid   (epu_req_valid),
      .prf_we          (prf_we),
      .prf_waddr       (prf_waddr),
      .prf_wdata       (prf_wdata)
   );

   cmt_redirect u_redirect
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .ctl             (ctl_i.redir),
      .cmt_fls0        (cmt_fls[0]),
      .cmt_pc0         (cmt_pc[PC_W-1:0]),
      .cmt_opera0      (cmt_opera[DW-1:0]),
      .refetch         (refetch),
      .exc_flush       (exc_flush),
      .exc_flush_tgt   (exc_flush_tgt),
      .cmt_is_bcc0     (cmt_is_bcc[0]),
      .cmt_is_breg0    (cmt_is_breg[0]),
      .cmt_is_brel0    (cmt_is_brel[0]),
      .cmt_bpu_upd0    (cmt_bpu_upd[BPU_UPD_W-1:0]),
      .flush_tgt       (flush_tgt),
      .bpu_wb          (bpu_wb),
      .bpu_wb_is_bcc   (bpu_wb_is_bcc),
      .bpu_wb_is_breg  (bpu_wb_is_breg),
      .bpu_wb_is_brel  (bpu_wb_is_brel),
      .bpu_wb_taken    (bpu_wb_taken),
      .bpu_wb_pc       (bpu_wb_pc),
      .bpu_wb_npc_act  (bpu_wb_npc_act),
      .bpu_wb_upd      (bpu_wb_upd)
   );

endmodule

/* sim/tb_cmt.sv */
module tb_cmt
   import ncpu_cfg_pkg::*;
   import cmt_ops_pkg::*;
();

   localparam int P = P_COMMIT_WIDTH_DFLT;
   localparam int CW = 1 << P;
   localparam int STIM_CYCLES = 1500;
   localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;   // Reset plus generous slack
   localparam logic [31:0] SEED = 32'h73ee_605a;

   logic clk, rst_n;
   logic [CW-1:0] cmt_valid, cmt_exc, cmt_fls, cmt_prd_we;
   logic [CW-1:0] cmt_is_bcc, cmt_is_breg, cmt_is_brel;
   logic [LSU_IOPW*CW-1:0] cmt_lsu_opc_bus;
   logic [EPU_IOPW*CW-1:0] cmt_epu_opc_bus;
   logic [PC_W*CW-1:0] cmt_pc;
   logic [DW*CW-1:0] cmt_opera;
   logic [BPU_UPD_W*CW-1:0] cmt_bpu_upd;
   logic [PRF_AW*CW-1:0] cmt_prd;
   logic lsu_wb_valid, epu_wb_valid, epu_wb_dout_sel, exc_flush, refetch;
   logic [DW-1:0] lsu_wb_dout, epu_wb_dout;
   logic [PC_W-1:0] exc_flush_tgt;
   logic [CW-1:0] cmt_fire;
   logic [P:0] cmt_pop_size;
   logic lsu_req_valid, epu_req_valid, prf_we, flush;
   logic [PRF_AW-1:0] prf_waddr;
   logic [DW-1:0] prf_wdata;
   logic [PC_W-1:0] flush_tgt, bpu_wb_pc, bpu_wb_npc_act;
   logic bpu_wb, bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel, bpu_wb_taken;
   logic [BPU_UPD_W-1:0] bpu_wb_upd;

   // Reference model state
   logic pend_m, unit_epu, se_m;
   logic [2:0] wait_cnt;
   logic [PC_W-1:0] se_tgt_m;
   logic [CW-1:0] lsu_need, epu_need, single, exp_fire;
   logic [P:0] exp_pop;
   logic done_m, head_req_m, commit_m, flush_m, blocked, head_br_m;

   logic [31:0] rng_state;
   int cycle_cnt;
   int hit_multi, hit_lsu, hit_epu, hit_fls, hit_refetch, hit_exc, hit_bpu;

   cmt_top #(.P_COMMIT_WIDTH(P)) dut_i (.*);

   function automatic logic [31:0] step_rng();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // New ROB window, valid slots form a prefix
   task automatic refill_slots();
      int n_valid;
      int cls;
      int br;
      logic [CW-1:0] v, exc, fls, bcc, breg, brel, we;
      logic [LSU_IOPW*CW-1:0] lop;
      logic [EPU_IOPW*CW-1:0] eop;
      v = '0;
      exc = '0;
      fls = '0;
      bcc = '0;
      breg = '0;
      brel = '0;
      we = '0;
      lop = '0;
      eop = '0;
      n_valid = step_rng() % (CW + 1);
      for (int i = 0; i < n_valid; i++)
      begin
         v[i] = 1'b1;
         we[i] = (step_rng() % 2) == 1;
         cls = step_rng() % 8;
         br = step_rng() % 3;
         case (cls)
            4: lop[i*LSU_IOPW +: LSU_IOPW] = (step_rng() % 15) + 1;
            5:
               if ((step_rng() % 2) == 1)
                  eop[i*EPU_IOPW +: EPU_IOPW] = (step_rng() % 63) + 1;
               else
                  exc[i] = 1'b1;
            6, 7:
            begin
               fls[i] = (cls == 7);                 // Mispredicted branch
               bcc[i] = (br == 0);
               breg[i] = (br == 1);
               brel[i] = (br == 2);
            end
            default: ;                               // Plain op
         endcase
         cmt_pc[i*PC_W +: PC_W] <= step_rng();
         cmt_opera[i*DW +: DW] <= step_rng();
         cmt_bpu_upd[i*BPU_UPD_W +: BPU_UPD_W] <= step_rng();
         cmt_prd[i*PRF_AW +: PRF_AW] <= step_rng();
      end
      cmt_valid <= v;
      cmt_exc <= exc;
      cmt_fls <= fls;
      cmt_is_bcc <= bcc;
      cmt_is_breg <= breg;
      cmt_is_brel <= brel;
      cmt_prd_we <= we;
      cmt_lsu_opc_bus <= lop;
      cmt_epu_opc_bus <= eop;
   endtask

   always_comb
   begin
      for (int i = 0; i < CW; i++)
      begin
         lsu_need[i] = !se_m && (cmt_lsu_opc_bus[i*LSU_IOPW +: LSU_IOPW] != '0);
         epu_need[i] = !se_m && ((cmt_epu_opc_bus[i*EPU_IOPW +: EPU_IOPW] != '0) || cmt_exc[i]);
         single[i] = lsu_need[i] || epu_need[i] || cmt_fls[i] ||
                     cmt_is_bcc[i] || cmt_is_breg[i] || cmt_is_brel[i];
      end
      head_br_m = cmt_is_bcc[0] || cmt_is_breg[0] || cmt_is_brel[0];
      done_m = lsu_wb_valid || epu_wb_valid;
      head_req_m = !pend_m && cmt_valid[0] && (lsu_need[0] || epu_need[0]);
      commit_m = done_m || !(pend_m || head_req_m);   // Stalled while a unit op is out
      flush_m = se_m || exc_flush;
      blocked = !commit_m || flush_m;
      exp_pop = '0;
      for (int k = 0; k < CW; k++)
      begin
         if (k > 0 && (single[k-1] || single[k]))
            blocked = 1'b1;
         exp_fire[k] = cmt_valid[k] && !blocked;
         exp_pop = exp_pop + exp_fire[k];
      end
   end

   always @(posedge clk)
   begin : stim_proc
      logic pend_n;
      logic epu_n;
      logic [2:0] cnt_n;
      if (!rst_n)
      begin
         pend_m <= 1'b0;
         unit_epu <= 1'b0;
         wait_cnt <= '0;
         se_m <= 1'b0;
         se_tgt_m <= '0;
      end
      else
      begin
         pend_n = pend_m;
         epu_n = unit_epu;
         cnt_n = wait_cnt;
         if (done_m)
            pend_n = 1'b0;
         else if (head_req_m)
         begin
            pend_n = 1'b1;
            epu_n = epu_need[0];
            cnt_n = step_rng() % 5;                 // 1 to 5 cycle latency
         end
         else if (pend_m && wait_cnt != 0)
            cnt_n = wait_cnt - 1'b1;
         pend_m <= pend_n;
         unit_epu <= epu_n;
         wait_cnt <= cnt_n;
         se_m <= exp_fire[0] && (cmt_fls[0] || refetch);
         if (exp_fire[0])
            se_tgt_m <= cmt_fls[0] ? cmt_opera[PC_W-1:0] : cmt_pc[PC_W-1:0] + 1'b1;

         if (exp_pop >= 2) hit_multi++;
         if (lsu_wb_valid) hit_lsu++;
         if (epu_wb_valid) hit_epu++;
         if (exp_fire[0] && cmt_fls[0]) hit_fls++;
         if (exp_fire[0] && refetch && !cmt_fls[0]) hit_refetch++;
         if (exc_flush && !se_m) hit_exc++;
         if (exp_fire[0] && head_br_m) hit_bpu++;

         lsu_wb_valid <= pend_n && cnt_n == 0 && !epu_n;
         epu_wb_valid <= pend_n && cnt_n == 0 && epu_n;
         lsu_wb_dout <= step_rng();
         epu_wb_dout <= step_rng();
         epu_wb_dout_sel <= (step_rng() % 2) == 1;
         refetch <= pend_n && cnt_n == 0 && epu_n && (step_rng() % 4 == 0);
         exc_flush <= (step_rng() % 32 == 0);
         exc_flush_tgt <= step_rng();
         if (!pend_n)
            refill_slots();                          // Head is held while pending
      end
   end

   a_rst_quiet: assert property (@(posedge clk) (!rst_n && cycle_cnt > 0) |->
      !flush && !lsu_req_valid && !epu_req_valid && !prf_we && !bpu_wb)
      else fail_run("an output was active during reset");
   a_fire: assert property (@(posedge clk) disable iff (!rst_n) cmt_fire == exp_fire)
      else report_mismatch("cmt_fire", $sampled(cmt_fire), $sampled(exp_fire));
   a_pop: assert property (@(posedge clk) disable iff (!rst_n) cmt_pop_size == exp_pop)
      else report_mismatch("cmt_pop_size", $sampled(cmt_pop_size), $sampled(exp_pop));
   a_lsu_req: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_req_valid == (head_req_m && lsu_need[0]))
      else report_mismatch("lsu_req_valid", $sampled(lsu_req_valid),
                           $sampled(head_req_m && lsu_need[0]));
   a_epu_req: assert property (@(posedge clk) disable iff (!rst_n)
      epu_req_valid == (head_req_m && epu_need[0]))
      else report_mismatch("epu_req_valid", $sampled(epu_req_valid),
                           $sampled(head_req_m && epu_need[0]));
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (pend_m && !done_m) |-> cmt_fire == '0)
      else report_mismatch("cmt_fire", $sampled(cmt_fire), 0);
   a_prf_we: assert property (@(posedge clk) disable iff (!rst_n)
      prf_we == (done_m && !flush_m && cmt_prd_we[0]))
      else report_mismatch("prf_we", $sampled(prf_we),
                           $sampled(done_m && !flush_m && cmt_prd_we[0]));
   a_prf_addr: assert property (@(posedge clk) disable iff (!rst_n)
      prf_we |-> prf_waddr == cmt_prd[PRF_AW-1:0])
      else report_mismatch("prf_waddr", $sampled(prf_waddr), $sampled(cmt_prd[PRF_AW-1:0]));
   a_prf_data: assert property (@(posedge clk) disable iff (!rst_n)
      prf_we |-> prf_wdata == (epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout))
      else report_mismatch("prf_wdata", $sampled(prf_wdata),
                           $sampled(epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout));
   a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush == flush_m)
      else report_mismatch("flush", $sampled(flush), $sampled(flush_m));
   a_flush_tgt: assert property (@(posedge clk) disable iff (!rst_n)
      flush_m |-> flush_tgt == (se_m ? se_tgt_m : exc_flush_tgt))
      else report_mismatch("flush_tgt", $sampled(flush_tgt),
                           $sampled(se_m ? se_tgt_m : exc_flush_tgt));
   a_bpu_wb: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb == (exp_fire[0] && head_br_m))
      else report_mismatch("bpu_wb", $sampled(bpu_wb), $sampled(exp_fire[0] && head_br_m));
   a_bpu_taken: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb |-> bpu_wb_taken == (cmt_bpu_upd[BPU_UPD_TAKEN] ^ cmt_fls[0]))
      else report_mismatch("bpu_wb_taken", $sampled(bpu_wb_taken),
                           $sampled(cmt_bpu_upd[BPU_UPD_TAKEN] ^ cmt_fls[0]));
   a_bpu_npc: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb |-> bpu_wb_npc_act == (cmt_fls[0] ? cmt_opera[PC_W-1:0] :
                                    cmt_bpu_upd[BPU_UPD_TGT_LSB +: PC_W]))
      else report_mismatch("bpu_wb_npc_act", $sampled(bpu_wb_npc_act),
                           $sampled(cmt_fls[0] ? cmt_opera[PC_W-1:0] :
                                    cmt_bpu_upd[BPU_UPD_TGT_LSB +: PC_W]));
   a_bpu_pc: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb |-> bpu_wb_pc == cmt_pc[PC_W-1:0])
      else report_mismatch("bpu_wb_pc", $sampled(bpu_wb_pc), $sampled(cmt_pc[PC_W-1:0]));
   a_bpu_upd: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb |-> bpu_wb_upd == cmt_bpu_upd[BPU_UPD_W-1:0])
      else report_mismatch("bpu_wb_upd", $sampled(bpu_wb_upd),
                           $sampled(cmt_bpu_upd[BPU_UPD_W-1:0]));
   a_bpu_type: assert property (@(posedge clk) disable iff (!rst_n)
      bpu_wb |-> {bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel} ==
                 {cmt_is_bcc[0], cmt_is_breg[0], cmt_is_brel[0]})
      else report_mismatch("bpu_wb_is_bcc/breg/brel",
                           $sampled({bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel}),
                           $sampled({cmt_is_bcc[0], cmt_is_breg[0], cmt_is_brel[0]}));

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         fail_run("simulation ran past its cycle limit");
   end

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      rst_n = 1'b0;
      rng_state = SEED;
      cycle_cnt = 0;
      hit_multi = 0;
      hit_lsu = 0;
      hit_epu = 0;
      hit_fls = 0;
      hit_refetch = 0;
      hit_exc = 0;
      hit_bpu = 0;
      cmt_valid = '0;
      cmt_exc = '0;
      cmt_fls = '0;
      cmt_prd_we = '0;
      cmt_is_bcc = '0;
      cmt_is_breg = '0;
      cmt_is_brel = '0;
      cmt_lsu_opc_bus = '0;
      cmt_epu_opc_bus = '0;
      cmt_pc = '0;
      cmt_opera = '0;
      cmt_bpu_upd = '0;
      cmt_prd = '0;
      lsu_wb_valid = 1'b0;
      epu_wb_valid = 1'b0;
      epu_wb_dout_sel = 1'b0;
      lsu_wb_dout = '0;
      epu_wb_dout = '0;
      exc_flush = 1'b0;
      exc_flush_tgt = '0;
      refetch = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      repeat (STIM_CYCLES) @(posedge clk);
      if (hit_multi == 0 || hit_lsu == 0 || hit_epu == 0 || hit_fls == 0 ||
          hit_refetch == 0 || hit_exc == 0 || hit_bpu == 0)
         fail_run("random stimulus did not reach every checked behaviour");
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

/* build.f */
rtl/ncpu_cfg_pkg.sv
rtl/cmt_ops_pkg.sv
rtl/cmt_ctl_if.sv
rtl/cmt_sel.sv
rtl/cmt_fu_seq.sv
rtl/cmt_redirect.sv
rtl/cmt_top.sv
sim/tb_cmt.sv

/* Bender.yml */
package:
  name: cmt_stage

sources:
  - rtl/ncpu_cfg_pkg.sv
  - rtl/cmt_ops_pkg.sv
  - rtl/cmt_ctl_if.sv
  - rtl/cmt_sel.sv
  - rtl/cmt_fu_seq.sv
  - rtl/cmt_redirect.sv
  - rtl/cmt_top.sv
  - target: simulation
    files:
      - sim/tb_cmt.sv
